// ==== common/riscv_isa_pkg.sv ====
/*
 RV32I/M encodings for the execute stage.
 Opcodes, funct3/funct7 values and instruction field positions.
 */
`default_nettype none

package riscv_isa_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // alu group, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_DIV  = 3'b100;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REM  = 3'b110;
    localparam logic [2:0] F3_REMU = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int SHAMT_LSB  = 20;
    localparam int FUNCT7_LSB = 25;
    localparam int IMM_I_LSB  = 20;

endpackage

`default_nettype wire

// ==== common/ex_stage_pkg.sv ====
/*
 Execute stage types.
 Datapath widths, divider sizing and the packed buses between
 decode, the stage, memory, the register file and the divider.
 */
`default_nettype none

package ex_stage_pkg;

    localparam int XLEN               = 32;
    localparam int REG_ADDR_W         = 5;
    localparam int LINK_OFFSET        = 4;
    localparam int DIV_BITS_PER_CYCLE = 4;   // must divide XLEN
    localparam int DIV_ITERS          = XLEN / DIV_BITS_PER_CYCLE;
    localparam int DIV_LATENCY        = DIV_ITERS + 1;
    localparam int DIV_CNT_W          = $clog2(DIV_ITERS);

    typedef struct packed {
        logic [31:0]           inst;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       store_data;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd_addr;
    } ex_issue_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } reg_wb_t;

    typedef struct packed {
        logic            flag;
        logic [XLEN-1:0] addr;
    } jump_t;

    typedef struct packed {
        logic [2:0]      op;  // funct3
        logic [XLEN-1:0] dividend;
        logic [XLEN-1:0] divisor;
    } div_req_t;

    // restoring divider state, quo starts as the dividend shifter
    typedef struct packed {
        logic [XLEN-1:0] rem;
        logic [XLEN-1:0] quo;
        logic [XLEN-1:0] divisor;
    } div_state_t;

endpackage

`default_nettype wire

// ==== hdl/ex_alu.sv ====
/*
 Execute stage ALU.
 Integer register/immediate operations, set-less-than, LUI/AUIPC,
 branch decision and jump target with link address.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_stage_pkg::ex_issue_t       issue_i,
    output logic [ex_stage_pkg::XLEN-1:0] alu_result_o,
    output ex_stage_pkg::jump_t           jump_o
);

    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [4:0]                    shamt;
    logic                          alt;
    logic                          is_op;
    logic [ex_stage_pkg::XLEN-1:0] op1;
    logic [ex_stage_pkg::XLEN-1:0] op2;
    logic [ex_stage_pkg::XLEN-1:0] sum;
    logic                          lt_s;
    logic                          lt_u;
    logic                          br_eq;
    logic                          br_lt;
    logic                          br_ltu;
    logic                          taken;

    always_comb begin
        opcode = issue_i.inst[riscv_isa_pkg::OPCODE_LSB +: 7];
        funct3 = issue_i.inst[riscv_isa_pkg::FUNCT3_LSB +: 3];
        funct7 = issue_i.inst[riscv_isa_pkg::FUNCT7_LSB +: 7];
        op1    = issue_i.op1;
        op2    = issue_i.op2;
        alt    = funct7 == riscv_isa_pkg::F7_ALT;
        is_op  = opcode == riscv_isa_pkg::OPC_OP && (funct7 == riscv_isa_pkg::F7_BASE || alt);
        shamt  = op2[4:0];  // rs2 or the immediate's low bits
        sum    = op1 + op2;
        lt_s   = $signed(op1) < $signed(op2);
        lt_u   = op1 < op2;
        br_eq  = issue_i.rs1_data == issue_i.rs2_data;
        br_lt  = $signed(issue_i.rs1_data) < $signed(issue_i.rs2_data);
        br_ltu = issue_i.rs1_data < issue_i.rs2_data;
    end

    always_comb begin
        alu_result_o = '0;
        taken        = 1'b0;
        if (is_op || opcode == riscv_isa_pkg::OPC_OP_IMM) begin
            case (funct3)
                riscv_isa_pkg::F3_ADD_SUB: alu_result_o = (is_op && alt) ? op1 - op2 : sum;
                riscv_isa_pkg::F3_SLL:     alu_result_o = op1 << shamt;
                riscv_isa_pkg::F3_SLT:     alu_result_o = {31'b0, lt_s};
                riscv_isa_pkg::F3_SLTU:    alu_result_o = {31'b0, lt_u};
                riscv_isa_pkg::F3_XOR:     alu_result_o = op1 ^ op2;
                riscv_isa_pkg::F3_SR: begin
                    if (alt) alu_result_o = $signed(op1) >>> shamt;
                    else alu_result_o = op1 >> shamt;
                end
                riscv_isa_pkg::F3_OR:      alu_result_o = op1 | op2;
                default:                   alu_result_o = op1 & op2;
            endcase
        end
        else if (opcode == riscv_isa_pkg::OPC_LUI || opcode == riscv_isa_pkg::OPC_AUIPC) begin
            alu_result_o = sum;  // decode puts 0 or pc in op1
        end
        else if (opcode == riscv_isa_pkg::OPC_JAL || opcode == riscv_isa_pkg::OPC_JALR) begin
            alu_result_o = issue_i.pc + ex_stage_pkg::XLEN'(ex_stage_pkg::LINK_OFFSET);
            taken        = 1'b1;
        end
        else if (opcode == riscv_isa_pkg::OPC_BRANCH) begin
            case (funct3)
                riscv_isa_pkg::F3_BEQ:  taken = br_eq;
                riscv_isa_pkg::F3_BNE:  taken = ~br_eq;
                riscv_isa_pkg::F3_BLT:  taken = br_lt;
                riscv_isa_pkg::F3_BGE:  taken = ~br_lt;
                riscv_isa_pkg::F3_BLTU: taken = br_ltu;
                riscv_isa_pkg::F3_BGEU: taken = ~br_ltu;
                default:                taken = 1'b0;
            endcase
        end
    end

    always_comb begin
        jump_o.flag = taken;
        jump_o.addr = taken ? sum : '0;
    end

endmodule

`default_nettype wire

// ==== hdl/ex_lsu.sv ====
/*
 Load/store unit of the execute stage.
 Forms the request and address, extends loaded lanes and merges
 stored lanes into the word read in the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_lsu (
    input  ex_stage_pkg::ex_issue_t       issue_i,
    input  logic [ex_stage_pkg::XLEN-1:0] mem_rdata_i,
    output ex_stage_pkg::mem_req_t        mem_o,
    output logic [ex_stage_pkg::XLEN-1:0] load_data_o
);

    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [ex_stage_pkg::XLEN-1:0] addr;
    logic [1:0]                    lane;
    logic [7:0]                    rd_byte;
    logic [15:0]                   rd_half;
    logic                          is_load;
    logic                          is_store;

    always_comb begin
        opcode   = issue_i.inst[riscv_isa_pkg::OPCODE_LSB +: 7];
        funct3   = issue_i.inst[riscv_isa_pkg::FUNCT3_LSB +: 3];
        is_load  = opcode == riscv_isa_pkg::OPC_LOAD;
        is_store = opcode == riscv_isa_pkg::OPC_STORE;
        addr     = issue_i.op1 + issue_i.op2;
        lane     = addr[1:0];
        rd_byte  = mem_rdata_i[{lane, 3'b000} +: 8];
        rd_half  = lane[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
    end

    always_comb begin
        case (funct3)
            riscv_isa_pkg::F3_LB:  load_data_o = {{24{rd_byte[7]}}, rd_byte};
            riscv_isa_pkg::F3_LBU: load_data_o = {24'b0, rd_byte};
            riscv_isa_pkg::F3_LH:  load_data_o = {{16{rd_half[15]}}, rd_half};
            riscv_isa_pkg::F3_LHU: load_data_o = {16'b0, rd_half};
            default:               load_data_o = mem_rdata_i;
        endcase
    end

    always_comb begin
        mem_o       = '0;
        mem_o.req   = is_load | is_store;
        mem_o.we    = is_store;
        mem_o.addr  = mem_o.req ? addr : '0;
        if (is_store) begin
            mem_o.wdata = mem_rdata_i;  // untouched lanes keep the read word
            case (funct3)
                riscv_isa_pkg::F3_SB: mem_o.wdata[{lane, 3'b000} +: 8] = issue_i.store_data[7:0];
                riscv_isa_pkg::F3_SH: mem_o.wdata[{lane[1], 4'b0000} +: 16] = issue_i.store_data[15:0];
                default:              mem_o.wdata = issue_i.store_data;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== divider/div_step.sv ====
/*
 One restoring division step.
 Shifts the next dividend bit into the partial remainder, subtracts
 the divisor when it fits and shifts in the quotient bit.
 */
`timescale 1ns/1ps
`default_nettype none

module div_step (
    input  ex_stage_pkg::div_state_t state_i,
    output ex_stage_pkg::div_state_t state_o
);

    logic [ex_stage_pkg::XLEN:0] trial;
    logic [ex_stage_pkg::XLEN:0] diff;
    logic                        fits;

    always_comb begin
        trial = {state_i.rem, state_i.quo[ex_stage_pkg::XLEN-1]};
        diff  = trial - {1'b0, state_i.divisor};
        fits  = ~diff[ex_stage_pkg::XLEN];  // no borrow
        state_o.rem     = fits ? diff[ex_stage_pkg::XLEN-1:0] : trial[ex_stage_pkg::XLEN-1:0];
        state_o.quo     = {state_i.quo[ex_stage_pkg::XLEN-2:0], fits};
        state_o.divisor = state_i.divisor;
    end

endmodule

`default_nettype wire

// ==== divider/div_iter_ctrl.sv ====
/*
 Divider iteration controller.
 Conditions the operands, holds the remainder/quotient state and
 counts DIV_ITERS passes through the step chain.
 */
`timescale 1ns/1ps
`default_nettype none

module div_iter_ctrl (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     valid_i,
    input  ex_stage_pkg::div_req_t   req_i,
    input  ex_stage_pkg::div_state_t step_state_i,
    output ex_stage_pkg::div_state_t step_state_o,
    output logic                     finish_o,
    output logic                     neg_q_o,
    output logic                     neg_r_o,
    output logic [2:0]               op_o,
    output logic                     zero_div_o
);

    typedef enum logic [1:0] {IDLE, RUN, FINISH, DONE} state_e;

    state_e                               state;
    logic [ex_stage_pkg::DIV_CNT_W-1:0]   count;
    logic                                 is_signed;
    logic                                 a_neg;
    logic                                 b_neg;

    always_comb begin
        is_signed = req_i.op == riscv_isa_pkg::F3_DIV || req_i.op == riscv_isa_pkg::F3_REM;
        a_neg     = is_signed & req_i.dividend[ex_stage_pkg::XLEN-1];
        b_neg     = is_signed & req_i.divisor[ex_stage_pkg::XLEN-1];
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
            count <= '0;
        end
        else begin
            case (state)
                IDLE: if (valid_i) begin
                    state <= RUN;
                    count <= ex_stage_pkg::DIV_CNT_W'(ex_stage_pkg::DIV_ITERS - 1);
                end
                RUN: begin
                    count <= count - 1'b1;
                    if (count == '0) state <= FINISH;
                end
                FINISH: state <= DONE;  // result registers on this edge
                default: state <= IDLE;  // done cycle, decode takes the instruction
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE && valid_i) begin
            step_state_o.rem     <= '0;
            step_state_o.quo     <= a_neg ? -req_i.dividend : req_i.dividend;
            step_state_o.divisor <= b_neg ? -req_i.divisor : req_i.divisor;
            neg_q_o              <= a_neg ^ b_neg;
            neg_r_o              <= a_neg;  // remainder follows the dividend
            zero_div_o           <= req_i.divisor == '0;
            op_o                 <= req_i.op;
        end
        else if (state == RUN) begin
            step_state_o <= step_state_i;
        end
    end

    assign finish_o = state == FINISH;

endmodule

`default_nettype wire

// ==== divider/div_result.sv ====
/*
 Divider result stage.
 Sign correction, quotient/remainder select, RISC-V divide-by-zero
 result, and the registered result with a one-cycle done pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module div_result (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          finish_i,
    input  ex_stage_pkg::div_state_t      state_i,
    input  logic                          neg_q_i,
    input  logic                          neg_r_i,
    input  logic [2:0]                    op_i,
    input  logic                          zero_div_i,
    output logic                          done_o,
    output logic [ex_stage_pkg::XLEN-1:0] data_o
);

    logic [ex_stage_pkg::XLEN-1:0] quo;
    logic [ex_stage_pkg::XLEN-1:0] rem;

    // min / -1 needs no special case, the magnitude quotient is already 2^31
    always_comb begin
        if (zero_div_i) quo = '1;
        else quo = neg_q_i ? -state_i.quo : state_i.quo;
        rem = neg_r_i ? -state_i.rem : state_i.rem;  // x / 0 leaves the dividend here
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) done_o <= 1'b0;
        else done_o <= finish_i;
    end

    always_ff @(posedge clk_i) begin
        if (finish_i) begin
            if (op_i == riscv_isa_pkg::F3_REM || op_i == riscv_isa_pkg::F3_REMU) data_o <= rem;
            else data_o <= quo;
        end
    end

endmodule

`default_nettype wire

// ==== divider/div_unit.sv ====
/*
 Iterative divider.
 The controller feeds a chain of radix-2 steps that retires
 DIV_BITS_PER_CYCLE quotient bits per cycle, the result stage drains it.
 */
`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          valid_i,
    input  ex_stage_pkg::div_req_t        req_i,
    output logic                          done_o,
    output logic [ex_stage_pkg::XLEN-1:0] data_o
);

    ex_stage_pkg::div_state_t chain [ex_stage_pkg::DIV_BITS_PER_CYCLE+1];
    logic                     finish;
    logic                     neg_q;
    logic                     neg_r;
    logic                     zero_div;
    logic [2:0]               op;

    div_iter_ctrl i_div_iter_ctrl (
        .clk_i,
        .reset_i,
        .valid_i,
        .req_i,
        .step_state_i(chain[ex_stage_pkg::DIV_BITS_PER_CYCLE]),
        .step_state_o(chain[0]),
        .finish_o    (finish),
        .neg_q_o     (neg_q),
        .neg_r_o     (neg_r),
        .op_o        (op),
        .zero_div_o  (zero_div)
    );

    for (genvar g = 0; g < ex_stage_pkg::DIV_BITS_PER_CYCLE; g++) begin : g_step
        div_step i_div_step (
            .state_i(chain[g]),
            .state_o(chain[g+1])
        );
    end

    div_result i_div_result (
        .clk_i,
        .reset_i,
        .finish_i  (finish),
        .state_i   (chain[0]),  // final state once finish is up
        .neg_q_i   (neg_q),
        .neg_r_i   (neg_r),
        .op_i      (op),
        .zero_div_i(zero_div),
        .done_o,
        .data_o
    );

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
/*
 RV32 execute stage.
 Combinational ALU and load/store paths, a multi-cycle divider for
 the divide group, writeback select and the ready/stall signal.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  ex_stage_pkg::ex_issue_t       issue_i,
    input  logic [ex_stage_pkg::XLEN-1:0] mem_rdata_i,
    input  logic                          mem_ready_i,
    output ex_stage_pkg::mem_req_t        mem_o,
    output ex_stage_pkg::reg_wb_t         wb_o,
    output ex_stage_pkg::jump_t           jump_o,
    output logic                          ready_o
);

    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic                          div_valid;
    logic                          div_done;
    logic [ex_stage_pkg::XLEN-1:0] div_data;
    logic [ex_stage_pkg::XLEN-1:0] alu_result;
    logic [ex_stage_pkg::XLEN-1:0] load_data;
    ex_stage_pkg::div_req_t        div_req;

    always_comb begin
        opcode    = issue_i.inst[riscv_isa_pkg::OPCODE_LSB +: 7];
        funct3    = issue_i.inst[riscv_isa_pkg::FUNCT3_LSB +: 3];
        div_valid = opcode == riscv_isa_pkg::OPC_OP
            && issue_i.inst[riscv_isa_pkg::FUNCT7_LSB +: 7] == riscv_isa_pkg::F7_MULDIV
            && (funct3 == riscv_isa_pkg::F3_DIV || funct3 == riscv_isa_pkg::F3_DIVU
                || funct3 == riscv_isa_pkg::F3_REM || funct3 == riscv_isa_pkg::F3_REMU);
        div_req.op       = funct3;
        div_req.dividend = issue_i.op1;
        div_req.divisor  = issue_i.op2;
    end

    always_comb begin
        wb_o.addr = issue_i.rd_addr;
        wb_o.we   = issue_i.rd_we;
        if (div_valid) begin
            wb_o.we   = issue_i.rd_we & div_done;  // only in the done cycle
            wb_o.data = div_data;
        end
        else if (opcode == riscv_isa_pkg::OPC_LOAD) wb_o.data = load_data;
        else wb_o.data = alu_result;
    end

    // stall on a pending memory access or an unfinished divide
    assign ready_o = ~(mem_o.req & ~mem_ready_i) & ~(div_valid & ~div_done);

    ex_alu i_ex_alu (
        .issue_i,
        .alu_result_o(alu_result),
        .jump_o
    );

    ex_lsu i_ex_lsu (
        .issue_i,
        .mem_rdata_i,
        .mem_o,
        .load_data_o(load_data)
    );

    div_unit i_div_unit (
        .clk_i,
        .reset_i,
        .valid_i(div_valid),
        .req_i  (div_req),
        .done_o (div_done),
        .data_o (div_data)
    );

endmodule

`default_nettype wire

// ==== testbench/ex_vectors.svh ====
/*
 Execute stage vectors, one instruction per row, rd = x3.
 arith: inst, op1, op2, result. branch (pc 0x100): inst, rs1, rs2, offset, taken, target.
 jump_link: inst, pc, op1, op2, target, link. load (base 0x1000): inst, word, offset, result.
 store (base 0x1000): inst, offset, data, word, merged. divide: inst, dividend, divisor, result.
 */
arith("addi", 32'hffb08193, 32'd10, 32'hfffffffb, 32'd5);
arith("add", 32'h002081b3, 32'h7fffffff, 32'h1, 32'h80000000);
arith("sub", 32'h402081b3, 32'd3, 32'd5, 32'hfffffffe);
arith("xor", 32'h0020c1b3, 32'hf0f0f0f0, 32'h0ff00ff0, 32'hff00ff00);
arith("sll", 32'h002091b3, 32'h80000001, 32'h21, 32'h2);
arith("srl", 32'h0020d1b3, 32'h80000000, 32'h4, 32'h08000000);
arith("sra", 32'h4020d1b3, 32'h80000000, 32'h4, 32'hf8000000);
arith("srai", 32'h4040d193, 32'h80000010, 32'h404, 32'hf8000001);
arith("slt", 32'h0020a1b3, 32'hffffffff, 32'h1, 32'h1);
arith("sltu", 32'h0020b1b3, 32'hffffffff, 32'h1, 32'h0);
arith("slti", 32'hfff0a193, 32'hfffffffe, 32'hffffffff, 32'h1);
arith("lui", 32'h123451b7, 32'h0, 32'h12345000, 32'h12345000);
branch("beq_taken", 32'h00208063, 32'd5, 32'd5, 32'h10, 1'b1, 32'h110);
branch("beq_not", 32'h00208063, 32'd5, 32'd6, 32'h10, 1'b0, 32'h0);
branch("bne_taken", 32'h00209063, 32'd5, 32'd6, 32'hfffffff0, 1'b1, 32'hf0);
branch("bne_not", 32'h00209063, 32'd5, 32'd5, 32'hfffffff0, 1'b0, 32'h0);
branch("blt_taken", 32'h0020c063, 32'hffffffff, 32'h1, 32'h20, 1'b1, 32'h120);
branch("blt_not", 32'h0020c063, 32'h1, 32'hffffffff, 32'h20, 1'b0, 32'h0);
branch("bgeu_taken", 32'h0020f063, 32'hffffffff, 32'h1, 32'h8, 1'b1, 32'h108);
branch("bgeu_not", 32'h0020f063, 32'h1, 32'hffffffff, 32'h8, 1'b0, 32'h0);
jump_link("jal", 32'h000001ef, 32'h200, 32'h200, 32'h40, 32'h240, 32'h204);
jump_link("jalr", 32'h000081e7, 32'h200, 32'h3000, 32'h8, 32'h3008, 32'h204);
load("lb_0", 32'h00008183, 32'h9a7fe102, 32'd0, 32'h00000002);
load("lb_1", 32'h00008183, 32'h9a7fe102, 32'd1, 32'hffffffe1);
load("lb_2", 32'h00008183, 32'h9a7fe102, 32'd2, 32'h0000007f);
load("lb_3", 32'h00008183, 32'h9a7fe102, 32'd3, 32'hffffff9a);
load("lbu_0", 32'h0000c183, 32'h9a7fe102, 32'd0, 32'h00000002);
load("lbu_1", 32'h0000c183, 32'h9a7fe102, 32'd1, 32'h000000e1);
load("lbu_2", 32'h0000c183, 32'h9a7fe102, 32'd2, 32'h0000007f);
load("lbu_3", 32'h0000c183, 32'h9a7fe102, 32'd3, 32'h0000009a);
load("lh_0", 32'h00009183, 32'h9a7fe102, 32'd0, 32'hffffe102);
load("lh_2", 32'h00009183, 32'h9a7fe102, 32'd2, 32'hffff9a7f);
load("lhu_0", 32'h0000d183, 32'h9a7fe102, 32'd0, 32'h0000e102);
load("lhu_2", 32'h0000d183, 32'h9a7fe102, 32'd2, 32'h00009a7f);
load("lw_0", 32'h0000a183, 32'h9a7fe102, 32'd0, 32'h9a7fe102);
store("sb_0", 32'h00208023, 32'd0, 32'hdeadbeef, 32'h11223344, 32'h112233ef);
store("sb_1", 32'h00208023, 32'd1, 32'hdeadbeef, 32'h11223344, 32'h1122ef44);
store("sb_2", 32'h00208023, 32'd2, 32'hdeadbeef, 32'h11223344, 32'h11ef3344);
store("sb_3", 32'h00208023, 32'd3, 32'hdeadbeef, 32'h11223344, 32'hef223344);
store("sh_0", 32'h00209023, 32'd0, 32'hdeadbeef, 32'h11223344, 32'h1122beef);
store("sh_2", 32'h00209023, 32'd2, 32'hdeadbeef, 32'h11223344, 32'hbeef3344);
store("sw_0", 32'h0020a023, 32'd0, 32'hdeadbeef, 32'h11223344, 32'hdeadbeef);
divide("div", 32'h0220c1b3, 32'd20, 32'hfffffffd, 32'hfffffffa);
divide("rem", 32'h0220e1b3, 32'd20, 32'hfffffffd, 32'h2);
divide("div_neg", 32'h0220c1b3, 32'hffffffec, 32'd3, 32'hfffffffa);
divide("rem_neg", 32'h0220e1b3, 32'hffffffec, 32'd3, 32'hfffffffe);
divide("divu", 32'h0220d1b3, 32'hfffffffe, 32'd3, 32'h55555554);
divide("remu", 32'h0220f1b3, 32'hfffffffe, 32'd3, 32'h2);
divide("div_zero", 32'h0220c1b3, 32'd7, 32'h0, 32'hffffffff);
divide("div_zero_neg", 32'h0220c1b3, 32'hfffffff9, 32'h0, 32'hffffffff);
divide("divu_zero", 32'h0220d1b3, 32'd7, 32'h0, 32'hffffffff);
divide("rem_zero", 32'h0220e1b3, 32'hfffffff9, 32'h0, 32'hfffffff9);
divide("remu_zero", 32'h0220f1b3, 32'd7, 32'h0, 32'd7);
divide("div_ovf", 32'h0220c1b3, 32'h80000000, 32'hffffffff, 32'h80000000);
divide("rem_ovf", 32'h0220e1b3, 32'h80000000, 32'hffffffff, 32'h0);
arith("add_after_div", 32'h002081b3, 32'd40, 32'd2, 32'd42);

// ==== testbench/tb_ex_stage.sv ====
/*
 Testbench for the RV32 execute stage.
 Applies the vector table one instruction at a time, models a memory
 that answers after a random wait and checks every stage output.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    localparam int CLK_HALF     = 4;
    localparam int SAMPLE_DELAY = 2;   // after the falling edge
    localparam int MAX_WAIT     = 32;

    typedef struct packed {
        ex_stage_pkg::ex_issue_t issue;
        logic [31:0]             rdata;
        logic [31:0]             wb_data;
        logic                    mem_req;
        logic                    mem_we;
        logic [31:0]             mem_addr;
        logic [31:0]             mem_wdata;
        logic                    jump_flag;
        logic [31:0]             jump_addr;
        logic [3:0]              latency;  // ready low edges apart from memory wait
    } vec_t;

    logic                    clk_i = 1'b0;
    logic                    reset_i;
    ex_stage_pkg::ex_issue_t issue_i;
    logic [31:0]             mem_rdata_i;
    logic                    mem_ready_i;
    ex_stage_pkg::mem_req_t  mem_o;
    ex_stage_pkg::reg_wb_t   wb_o;
    ex_stage_pkg::jump_t     jump_o;
    logic                    ready_o;

    vec_t   vectors [$];
    string  names [$];
    integer seed = 32'h19420ff8;

    always #CLK_HALF clk_i = ~clk_i;

    ex_stage i_ex_stage (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s %s: expected %h, actual %h", test, what, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic vec_t blank_entry(input logic [31:0] inst, pc, op1, op2, rs1, rs2);
        vec_t v;
        v                  = '0;
        v.issue.inst       = inst;
        v.issue.pc         = pc;
        v.issue.op1        = op1;
        v.issue.op2        = op2;
        v.issue.rs1_data   = rs1;
        v.issue.rs2_data   = rs2;
        v.issue.store_data = rs2;  // decode forwards rs2
        v.issue.rd_we      = 1'b1;
        v.issue.rd_addr    = inst[11:7];
        return v;
    endfunction

    function automatic void enqueue(input string name, input vec_t v);
        names.push_back(name);
        vectors.push_back(v);
    endfunction

    function automatic void arith(input string name, input logic [31:0] inst, op1, op2, result);
        vec_t v;
        v         = blank_entry(inst, 32'h0, op1, op2, op1, op2);
        v.wb_data = result;
        enqueue(name, v);
    endfunction

    function automatic void branch(input string name, input logic [31:0] inst, rs1, rs2, off,
                                   input logic taken, input logic [31:0] target);
        vec_t v;
        v             = blank_entry(inst, 32'h100, 32'h100, off, rs1, rs2);
        v.issue.rd_we = 1'b0;
        v.jump_flag   = taken;
        v.jump_addr   = target;
        enqueue(name, v);
    endfunction

    function automatic void jump_link(input string name,
                                      input logic [31:0] inst, pc, op1, op2, target, link);
        vec_t v;
        v           = blank_entry(inst, pc, op1, op2, op1, op2);
        v.wb_data   = link;
        v.jump_flag = 1'b1;
        v.jump_addr = target;
        enqueue(name, v);
    endfunction

    function automatic void load(input string name, input logic [31:0] inst, word, off, result);
        vec_t v;
        v          = blank_entry(inst, 32'h0, 32'h1000, off, 32'h1000, 32'h0);
        v.rdata    = word;
        v.wb_data  = result;
        v.mem_req  = 1'b1;
        v.mem_addr = 32'h1000 + off;
        enqueue(name, v);
    endfunction

    function automatic void store(input string name,
                                  input logic [31:0] inst, off, data, word, merged);
        vec_t v;
        v             = blank_entry(inst, 32'h0, 32'h1000, off, 32'h1000, data);
        v.issue.rd_we = 1'b0;
        v.rdata       = word;
        v.mem_req     = 1'b1;
        v.mem_we      = 1'b1;
        v.mem_addr    = 32'h1000 + off;
        v.mem_wdata   = merged;
        enqueue(name, v);
    endfunction

    function automatic void divide(input string name, input logic [31:0] inst, a, b, result);
        vec_t v;
        v         = blank_entry(inst, 32'h0, a, b, a, b);
        v.wb_data = result;
        v.latency = 4'(ex_stage_pkg::DIV_LATENCY + 1);  // start edge, then the latency
        enqueue(name, v);
    endfunction

    task automatic build_vectors();
        `include "ex_vectors.svh"
    endtask

    task automatic run_entry(input string name, input vec_t v);
        ex_stage_pkg::mem_req_t mem_snap;
        ex_stage_pkg::reg_wb_t  wb_snap;
        int                     mem_wait;
        int                     stalls;
        mem_wait = v.mem_req ? int'($unsigned($random(seed)) % 4) : 0;
        @(negedge clk_i);
        issue_i     = v.issue;
        mem_rdata_i = v.rdata;
        mem_ready_i = mem_wait == 0;
        #SAMPLE_DELAY;
        stalls   = 0;
        mem_snap = mem_o;
        wb_snap  = wb_o;
        while (!ready_o) begin
            if (v.latency != 0) check_value(name, "wb_o.we while busy", 32'h0, 32'(wb_o.we));
            assert ({mem_o, wb_o} === {mem_snap, wb_snap})
            else abort_run($sformatf("%s: outputs changed while the stage was stalled", name));
            @(posedge clk_i);
            stalls++;
            if (stalls > MAX_WAIT)
                abort_run($sformatf("%s: ready_o stayed low for %0d cycles", name, stalls));
            @(negedge clk_i);
            if (stalls == mem_wait) mem_ready_i = 1'b1;  // memory answers
            #SAMPLE_DELAY;
        end
        check_value(name, "stall cycles", mem_wait + v.latency, stalls);
        check_value(name, "wb_o.we", 32'(v.issue.rd_we), 32'(wb_o.we));
        check_value(name, "wb_o.addr", 32'(v.issue.rd_addr), 32'(wb_o.addr));
        if (v.issue.rd_we) check_value(name, "wb_o.data", v.wb_data, wb_o.data);
        check_value(name, "mem_o.req", 32'(v.mem_req), 32'(mem_o.req));
        check_value(name, "mem_o.we", 32'(v.mem_we), 32'(mem_o.we));
        if (v.mem_req) check_value(name, "mem_o.addr", v.mem_addr, mem_o.addr);
        if (v.mem_we) check_value(name, "mem_o.wdata", v.mem_wdata, mem_o.wdata);
        check_value(name, "jump_o.flag", 32'(v.jump_flag), 32'(jump_o.flag));
        if (v.jump_flag) check_value(name, "jump_o.addr", v.jump_addr, jump_o.addr);
        @(posedge clk_i);  // decode takes the instruction
    endtask

    initial begin
        reset_i     = 1'b1;
        issue_i     = '0;
        mem_rdata_i = '0;
        mem_ready_i = 1'b1;
        build_vectors();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        for (int i = 0; i < vectors.size(); i++) run_entry(names[i], vectors[i]);
        if (vectors.size() == 0) begin
            abort_run("the vector table holds no entries");
        end
        else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+testbench
common/riscv_isa_pkg.sv
common/ex_stage_pkg.sv
hdl/ex_alu.sv
hdl/ex_lsu.sv
divider/div_step.sv
divider/div_iter_ctrl.sv
divider/div_result.sv
divider/div_unit.sv
hdl/ex_stage.sv
testbench/tb_ex_stage.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_ex_stage
FILELIST  := list.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard common/*.sv hdl/*.sv divider/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
